// File: hw/rename_pkg.sv
////////////////////////////////////////////////////////////////////////////
// shared sizes and types for the rename and issue subsystem
// imported by every interface and module of the design
////////////////////////////////////////////////////////////////////////////
package rename_pkg;

  // machine sizes
  localparam int NUM_LREGS  = 16;
  localparam int LREG_BITS  = $clog2(NUM_LREGS);
  localparam int PREG_BITS  = 6;
  localparam int NUM_PREGS  = 64;
  localparam int IMM_BITS   = 8;
  localparam int ISQ_DEPTH  = 4;
  localparam int EXEC_LAT   = 3;

  // pregs not held by the reset map start out in the free list
  localparam int FREE_DEPTH    = NUM_PREGS - NUM_LREGS;
  localparam int FREE_PTR_BITS = $clog2(FREE_DEPTH);
  localparam int FREE_CNT_BITS = $clog2(FREE_DEPTH + 1);
  localparam int ISQ_CNT_BITS  = $clog2(ISQ_DEPTH + 1);

  // opcodes are only carried along, no datapath behind them
  typedef enum logic [2:0] {
    add,
    sub,
    and_op,
    or_op,
    mov
  } op_e;

  // one map entry, ready flag above the preg index (7 bits)
  typedef struct packed {
    logic                 rdy;
    logic [PREG_BITS-1:0] preg;
  } map_entry_t;

  // full logical to physical map, entry 0 in the low bits
  typedef map_entry_t [NUM_LREGS-1:0] reg_map_t;

  typedef struct packed {
    logic                 valid;
    logic [LREG_BITS-1:0] idx;
  } lreg_ref_t;

  typedef struct packed {
    logic                 valid;
    logic [PREG_BITS-1:0] preg;
  } preg_ref_t;

  // decoded instruction as it enters the rename stage
  typedef struct packed {
    op_e                 op;
    lreg_ref_t           src1;
    lreg_ref_t           src2;
    lreg_ref_t           dst;
    logic [IMM_BITS-1:0] imm;
  } inst_t;

  // instruction after renaming, as handed to execution
  typedef struct packed {
    op_e                  op;
    logic [IMM_BITS-1:0]  imm;
    preg_ref_t            psrc1;
    preg_ref_t            psrc2;
    logic                 pdst_valid;
    logic [PREG_BITS-1:0] pdst;
    // preg released once this instruction writes back
    logic                 old_valid;
    logic [PREG_BITS-1:0] old_preg;
  } renamed_inst_t;

  // state of one issue queue slot, moved down on shift
  typedef struct packed {
    logic                 valid;
    inst_t                inst;
    logic [PREG_BITS-1:0] pdst;
    logic                 dst_rdy;
  } slot_t;

endpackage

// File: hw/rename_ifs.sv
////////////////////////////////////////////////////////////////////////////
// dispatch and writeback bundles used between the rename blocks
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

// allocator to issue queue, transfer when valid and accept are both high
interface dispatch_if
  import rename_pkg::*;
();
  logic                 valid;
  inst_t                inst;
  logic [PREG_BITS-1:0] pdst;
  logic                 accept;

  modport producer (output valid, output inst, output pdst, input accept);
  modport queue (input valid, input inst, input pdst, output accept);
endinterface

// one-cycle pulses from the execution pipe
interface wb_if
  import rename_pkg::*;
();
  // destination preg now holds its result
  logic                 wb_valid;
  logic [PREG_BITS-1:0] wb_preg;
  // superseded preg goes back to the free list
  logic                 free_valid;
  logic [PREG_BITS-1:0] free_preg;

  modport exec (output wb_valid, output wb_preg, output free_valid, output free_preg);
  modport queue (input wb_valid, input wb_preg);
  modport alloc (input free_valid, input free_preg);
endinterface

// File: hw/preg_alloc.sv
////////////////////////////////////////////////////////////////////////////
// physical register allocator, a circular free-list FIFO that tags each
// accepted instruction with the preg at its head
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module preg_alloc
  import rename_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        inst_valid_i,
  input  inst_t       inst_i,
  output logic        inst_accept_o,
  dispatch_if.producer disp,
  wb_if.alloc         wb
);

  logic [PREG_BITS-1:0]     fifo_q [FREE_DEPTH];
  logic [FREE_PTR_BITS-1:0] rd_ptr_q;
  logic [FREE_PTR_BITS-1:0] wr_ptr_q;
  logic [FREE_CNT_BITS-1:0] count_q;
  logic                     empty;
  logic                     dst_ok;
  logic                     pop;
  logic                     push;

  // wrap at the end of the storage, depth is not a power of two
  function automatic logic [FREE_PTR_BITS-1:0] ptr_inc(input logic [FREE_PTR_BITS-1:0] p);
    logic [FREE_PTR_BITS-1:0] nxt;
    if (p == FREE_PTR_BITS'(FREE_DEPTH - 1))
      nxt = '0;
    else
      nxt = p + 1'b1;
    return nxt;
  endfunction

  assign empty = (count_q == '0);
  // an instruction without destination needs no preg
  assign dst_ok = !empty || !inst_i.dst.valid;

  ////////////////////////////////////////////////////////////////////////////
  // dispatch side
  ////////////////////////////////////////////////////////////////////////////
  assign disp.valid    = inst_valid_i && dst_ok;
  assign disp.inst     = inst_i;
  // head of the list, only consumed when dst is valid
  assign disp.pdst     = fifo_q[rd_ptr_q];
  assign inst_accept_o = disp.accept && dst_ok;

  assign pop  = disp.valid && disp.accept && inst_i.dst.valid;
  assign push = wb.free_valid;

  ////////////////////////////////////////////////////////////////////////////
  // free list storage
  ////////////////////////////////////////////////////////////////////////////
  // after reset the list holds every preg above the identity map
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < FREE_DEPTH; i++)
        fifo_q[i] <= PREG_BITS'(i + NUM_LREGS);
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= FREE_CNT_BITS'(FREE_DEPTH);
    end
    else
    begin
      // returned preg is visible at the head from the next cycle
      if (push)
      begin
        fifo_q[wr_ptr_q] <= wb.free_preg;
        wr_ptr_q         <= ptr_inc(wr_ptr_q);
      end
      if (pop)
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      // push and pop together leave the count alone
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

// File: hw/rename_line.sv
////////////////////////////////////////////////////////////////////////////
// one issue queue slot, renames its sources through the incoming map and
// passes the map on with its own destination written in
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module rename_line
  import rename_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 load_i,
  input  logic                 shift_in_i,
  input  inst_t                inst_i,
  input  logic [PREG_BITS-1:0] pdst_i,
  input  slot_t                next_line_i,
  input  reg_map_t             prv_map_i,
  input  logic                 wb_valid_i,
  input  logic [PREG_BITS-1:0] wb_preg_i,
  output reg_map_t             cur_map_o,
  output renamed_inst_t        renamed_o,
  output logic                 inst_rdy_o,
  output slot_t                line_o
);

  logic                 valid_q;
  logic                 dst_rdy_q;
  inst_t                inst_q;
  logic [PREG_BITS-1:0] pdst_q;

  map_entry_t src1_map;
  map_entry_t src2_map;
  map_entry_t old_map;
  logic       src1_vld;
  logic       src2_vld;
  logic       has_dst;
  logic       src1_rdy;
  logic       src2_rdy;
  logic       own_hit;
  logic       next_hit;

  ////////////////////////////////////////////////////////////////////////////
  // slot registers
  ////////////////////////////////////////////////////////////////////////////
  assign own_hit  = wb_valid_i && (wb_preg_i == pdst_q);
  // entry moving in from above also sees this cycle's writeback
  assign next_hit = wb_valid_i && (wb_preg_i == next_line_i.pdst);

  // load wins over shift, the tail slot is picked by the queue
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      valid_q   <= 1'b0;
      dst_rdy_q <= 1'b0;
    end
    else if (load_i)
    begin
      // new destination blocks everything behind it
      valid_q   <= 1'b1;
      dst_rdy_q <= 1'b0;
    end
    else if (shift_in_i)
    begin
      valid_q   <= next_line_i.valid;
      dst_rdy_q <= next_line_i.dst_rdy || next_hit;
    end
    else if (own_hit)
      dst_rdy_q <= 1'b1;
  end

  always_ff @(posedge clk)
  begin
    if (load_i)
    begin
      inst_q <= inst_i;
      pdst_q <= pdst_i;
    end
    else if (shift_in_i)
    begin
      inst_q <= next_line_i.inst;
      pdst_q <= next_line_i.pdst;
    end
  end

  assign line_o = '{valid: valid_q, inst: inst_q, pdst: pdst_q, dst_rdy: dst_rdy_q};

  ////////////////////////////////////////////////////////////////////////////
  // source lookup and map update
  ////////////////////////////////////////////////////////////////////////////
  assign src1_vld = valid_q && inst_q.src1.valid;
  assign src2_vld = valid_q && inst_q.src2.valid;
  assign has_dst  = valid_q && inst_q.dst.valid;

  assign src1_map = prv_map_i[inst_q.src1.idx];
  assign src2_map = prv_map_i[inst_q.src2.idx];
  // mapping displaced by this destination
  assign old_map  = prv_map_i[inst_q.dst.idx];

  // absent source or empty slot never blocks
  assign src1_rdy   = !src1_vld || src1_map.rdy;
  assign src2_rdy   = !src2_vld || src2_map.rdy;
  assign inst_rdy_o = src1_rdy && src2_rdy;

  always_comb
  begin
    cur_map_o = prv_map_i;
    if (has_dst)
    begin
      cur_map_o[inst_q.dst.idx].rdy  = dst_rdy_q;
      cur_map_o[inst_q.dst.idx].preg = pdst_q;
    end
  end

  // unused preg fields are zeroed
  always_comb
  begin
    renamed_o             = '0;
    renamed_o.op          = inst_q.op;
    renamed_o.imm         = inst_q.imm;
    renamed_o.psrc1.valid = src1_vld;
    renamed_o.psrc2.valid = src2_vld;
    renamed_o.pdst_valid  = has_dst;
    renamed_o.old_valid   = has_dst;
    if (src1_vld)
      renamed_o.psrc1.preg = src1_map.preg;
    if (src2_vld)
      renamed_o.psrc2.preg = src2_map.preg;
    if (has_dst)
    begin
      renamed_o.pdst     = pdst_q;
      renamed_o.old_preg = old_map.preg;
    end
  end

endmodule

// File: hw/issue_queue.sv
////////////////////////////////////////////////////////////////////////////
// in-order issue queue, a shifting chain of rename lines behind a base map
// that absorbs each line as it issues from the head
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module issue_queue
  import rename_pkg::*;
(
  input  logic          clk,
  input  logic          rst_n,
  dispatch_if.queue     disp,
  wb_if.queue           wb,
  output logic          issue_valid_o,
  output renamed_inst_t issue_inst_o
);

  reg_map_t                base_map_q;
  logic [ISQ_CNT_BITS-1:0] count_q;
  logic [ISQ_CNT_BITS-1:0] load_idx;
  logic                    transfer;
  logic                    issue;

  // per slot results
  reg_map_t      cur_map_s [ISQ_DEPTH];
  slot_t         line_s    [ISQ_DEPTH];
  renamed_inst_t renamed_s [ISQ_DEPTH];
  logic          rdy_s     [ISQ_DEPTH];

  // set the ready flag of every entry mapped to the written preg
  function automatic reg_map_t mark_ready(input reg_map_t m, input logic v,
                                          input logic [PREG_BITS-1:0] p);
    reg_map_t r;
    r = m;
    for (int i = 0; i < NUM_LREGS; i++)
    begin
      if (v && (r[i].preg == p))
        r[i].rdy = 1'b1;
    end
    return r;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // occupancy and slot select
  ////////////////////////////////////////////////////////////////////////////
  assign disp.accept = (count_q < ISQ_CNT_BITS'(ISQ_DEPTH));
  assign transfer    = disp.valid && disp.accept;

  // only the head may leave
  assign issue = line_s[0].valid && rdy_s[0];

  // a load during issue lands behind the shifted entries
  assign load_idx = issue ? (count_q - 1'b1) : count_q;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      count_q <= '0;
    else
    begin
      case ({transfer, issue})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // slot chain
  ////////////////////////////////////////////////////////////////////////////
  for (genvar k = 0; k < ISQ_DEPTH; k++)
  begin : g_slot
    reg_map_t prv_map;
    slot_t    next_line;

    // slot 0 reads the committed map, the others the slot ahead
    if (k == 0)
    begin : g_head
      assign prv_map = base_map_q;
    end
    else
    begin : g_body
      assign prv_map = cur_map_s[k-1];
    end

    // nothing above the last slot, it empties on shift
    if (k == ISQ_DEPTH - 1)
    begin : g_top
      assign next_line = '0;
    end
    else
    begin : g_below
      assign next_line = line_s[k+1];
    end

    rename_line u_line (
      .clk         (clk),
      .rst_n       (rst_n),
      .load_i      (transfer && (load_idx == ISQ_CNT_BITS'(k))),
      .shift_in_i  (issue),
      .inst_i      (disp.inst),
      .pdst_i      (disp.pdst),
      .next_line_i (next_line),
      .prv_map_i   (prv_map),
      .wb_valid_i  (wb.wb_valid),
      .wb_preg_i   (wb.wb_preg),
      .cur_map_o   (cur_map_s[k]),
      .renamed_o   (renamed_s[k]),
      .inst_rdy_o  (rdy_s[k]),
      .line_o      (line_s[k])
    );
  end

  ////////////////////////////////////////////////////////////////////////////
  // base map
  ////////////////////////////////////////////////////////////////////////////
  // reset to identity, all ready
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < NUM_LREGS; i++)
      begin
        base_map_q[i].rdy  <= 1'b1;
        base_map_q[i].preg <= PREG_BITS'(i);
      end
    end
    else if (issue)
      // issued head folds its destination into the base map
      base_map_q <= mark_ready(cur_map_s[0], wb.wb_valid, wb.wb_preg);
    else
      base_map_q <= mark_ready(base_map_q, wb.wb_valid, wb.wb_preg);
  end

  assign issue_valid_o = issue;
  assign issue_inst_o  = renamed_s[0];

endmodule

// File: hw/exec_pipe.sv
////////////////////////////////////////////////////////////////////////////
// fixed latency execution stand-in, a shift pipe that emits the writeback
// and free pulses EXEC_LAT cycles after issue
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module exec_pipe
  import rename_pkg::*;
(
  input  logic          clk,
  input  logic          rst_n,
  input  logic          issue_valid_i,
  input  renamed_inst_t issue_inst_i,
  wb_if.exec            wb
);

  // stage 0 is loaded on the issue edge
  logic [EXEC_LAT-1:0]  wb_v_q;
  logic [EXEC_LAT-1:0]  free_v_q;
  logic [PREG_BITS-1:0] pdst_q [EXEC_LAT];
  logic [PREG_BITS-1:0] old_q  [EXEC_LAT];

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wb_v_q   <= '0;
      free_v_q <= '0;
    end
    else
    begin
      wb_v_q   <= {wb_v_q[EXEC_LAT-2:0], issue_valid_i && issue_inst_i.pdst_valid};
      free_v_q <= {free_v_q[EXEC_LAT-2:0], issue_valid_i && issue_inst_i.old_valid};
    end
  end

  always_ff @(posedge clk)
  begin
    pdst_q[0] <= issue_inst_i.pdst;
    old_q[0]  <= issue_inst_i.old_preg;
    for (int s = 1; s < EXEC_LAT; s++)
    begin
      pdst_q[s] <= pdst_q[s-1];
      old_q[s]  <= old_q[s-1];
    end
  end

  // last stage drives the broadcast
  assign wb.wb_valid   = wb_v_q[EXEC_LAT-1];
  assign wb.wb_preg    = pdst_q[EXEC_LAT-1];
  assign wb.free_valid = free_v_q[EXEC_LAT-1];
  assign wb.free_preg  = old_q[EXEC_LAT-1];

endmodule

// File: hw/rename_unit_top.sv
////////////////////////////////////////////////////////////////////////////
// rename and issue subsystem top, allocator feeding the issue queue and
// the execution pipe closing the loop through writeback
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module rename_unit_top
  import rename_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 inst_valid_i,
  input  inst_t                inst_i,
  output logic                 inst_accept_o,
  output logic                 issue_valid_o,
  output renamed_inst_t        issue_inst_o,
  output logic                 wb_valid_o,
  output logic [PREG_BITS-1:0] wb_preg_o
);

  dispatch_if disp ();
  wb_if       wb ();

  // producer, attaches pdst from the free list
  preg_alloc u_alloc (
    .clk           (clk),
    .rst_n         (rst_n),
    .inst_valid_i  (inst_valid_i),
    .inst_i        (inst_i),
    .inst_accept_o (inst_accept_o),
    .disp          (disp),
    .wb            (wb)
  );

  // buffer, renames and issues in order
  issue_queue u_isq (
    .clk           (clk),
    .rst_n         (rst_n),
    .disp          (disp),
    .wb            (wb),
    .issue_valid_o (issue_valid_o),
    .issue_inst_o  (issue_inst_o)
  );

  // consumer, fixed latency writeback
  exec_pipe u_exec (
    .clk           (clk),
    .rst_n         (rst_n),
    .issue_valid_i (issue_valid_o),
    .issue_inst_i  (issue_inst_o),
    .wb            (wb)
  );

  assign wb_valid_o = wb.wb_valid;
  assign wb_preg_o  = wb.wb_preg;

endmodule

// File: sim/rename_model.svh
////////////////////////////////////////////////////////////////////////////
// reference model of the rename unit, included into the testbench module
// tracks the map, the free list, pending issues and preg ready times
////////////////////////////////////////////////////////////////////////////
`ifndef RENAME_MODEL_SVH
`define RENAME_MODEL_SVH

// one writeback the model expects from the execution pipe
typedef struct {
  int                   due;
  logic [PREG_BITS-1:0] pdst;
  logic                 old_valid;
  logic [PREG_BITS-1:0] old_preg;
} wb_rec_t;

localparam int NEVER = 32'h7fff_ffff;

// logical to physical map as seen by the next accepted instruction
logic [PREG_BITS-1:0] arch_map [NUM_LREGS];
// free list, recycled pregs appended in writeback order
logic [PREG_BITS-1:0] free_q [$];
// expected renamed instructions in accept order
renamed_inst_t        exp_q [$];
// writebacks still to come, in issue order
wb_rec_t              wb_q [$];
// first cycle in which a reader of the preg may issue
int                   ready_at [NUM_PREGS];

function automatic void reset_model();
  free_q.delete();
  exp_q.delete();
  wb_q.delete();
  // identity map, all reset pregs usable at once
  for (int i = 0; i < NUM_LREGS; i++)
    arch_map[i] = PREG_BITS'(i);
  for (int p = 0; p < NUM_PREGS; p++)
    ready_at[p] = 0;
  for (int i = 0; i < FREE_DEPTH; i++)
    free_q.push_back(PREG_BITS'(NUM_LREGS + i));
endfunction

// rename at accept time, sources read before the own destination lands
function automatic renamed_inst_t rename_inst(input inst_t inst);
  renamed_inst_t r;
  r     = '0;
  r.op  = inst.op;
  r.imm = inst.imm;
  if (inst.src1.valid)
  begin
    r.psrc1.valid = 1'b1;
    r.psrc1.preg  = arch_map[inst.src1.idx];
  end
  if (inst.src2.valid)
  begin
    r.psrc2.valid = 1'b1;
    r.psrc2.preg  = arch_map[inst.src2.idx];
  end
  if (inst.dst.valid)
  begin
    r.pdst_valid = 1'b1;
    r.pdst       = free_q.pop_front();
    r.old_valid  = 1'b1;
    r.old_preg   = arch_map[inst.dst.idx];
    arch_map[inst.dst.idx] = r.pdst;
    // not readable until its own writeback
    ready_at[r.pdst] = NEVER;
  end
  return r;
endfunction

function automatic bit sources_ready(input renamed_inst_t r, input int now);
  bit ok;
  ok = 1'b1;
  if (r.psrc1.valid && (now < ready_at[r.psrc1.preg]))
    ok = 1'b0;
  if (r.psrc2.valid && (now < ready_at[r.psrc2.preg]))
    ok = 1'b0;
  return ok;
endfunction

`endif

// File: sim/rename_tb.sv
////////////////////////////////////////////////////////////////////////////
// testbench for the rename unit, random and dependent instruction streams
// checked against the included model at issue and writeback
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module rename_tb
  import rename_pkg::*;
();

  localparam int SEED         = 62277;
  localparam int RESET_CYCLES = 10;
  localparam int NUM_RANDOM   = 320;
  localparam int NUM_CHAIN    = 80;
  localparam int NUM_INSTS    = NUM_RANDOM + NUM_CHAIN;
  localparam int MAX_GAP      = 3;
  localparam int CHAIN_REG    = 3;
  // budget per instruction covers queue, pipe and a few idle cycles
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + NUM_INSTS * (ISQ_DEPTH + EXEC_LAT + 4);

  logic                 clk = 1'b0;
  logic                 rst_n;
  logic                 inst_valid_i;
  inst_t                inst_i;
  logic                 inst_accept_o;
  logic                 issue_valid_o;
  renamed_inst_t        issue_inst_o;
  logic                 wb_valid_o;
  logic [PREG_BITS-1:0] wb_preg_o;

  int cycle    = 0;
  int errors   = 0;
  int checks   = 0;
  int accepted = 0;
  int issued   = 0;
  int wb_count = 0;
  bit stall_seen;

  `include "rename_model.svh"

  rename_unit_top uut (
    .clk           (clk),
    .rst_n         (rst_n),
    .inst_valid_i  (inst_valid_i),
    .inst_i        (inst_i),
    .inst_accept_o (inst_accept_o),
    .issue_valid_o (issue_valid_o),
    .issue_inst_o  (issue_inst_o),
    .wb_valid_o    (wb_valid_o),
    .wb_preg_o     (wb_preg_o)
  );

  always #5 clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////////////
  task automatic check_issue(input renamed_inst_t got, input renamed_inst_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("error at %0t ns: issued instruction got %h expected %h", $time, got, exp);
    end
  endtask

  task automatic check_wb_preg(input logic [PREG_BITS-1:0] got,
                               input logic [PREG_BITS-1:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("error at %0t ns: writeback preg got %0d expected %0d", $time, got, exp);
    end
  endtask

  task automatic check_accept(input logic got, input logic exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("error at %0t ns: inst_accept_o got %b expected %b", $time, got, exp);
    end
  endtask

  task automatic report_failure(input string msg);
    errors++;
    $display("%s (at %0t ns)", msg, $time);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////////
  function automatic inst_t random_inst();
    inst_t inst;
    inst.op         = op_e'($urandom_range(0, 4));
    inst.src1.valid = ($urandom_range(0, 3) != 0);
    inst.src1.idx   = LREG_BITS'($urandom_range(0, NUM_LREGS - 1));
    inst.src2.valid = ($urandom_range(0, 3) != 0);
    inst.src2.idx   = LREG_BITS'($urandom_range(0, NUM_LREGS - 1));
    // some instructions without destination, like stores
    inst.dst.valid  = ($urandom_range(0, 7) != 0);
    inst.dst.idx    = LREG_BITS'($urandom_range(0, NUM_LREGS - 1));
    inst.imm        = IMM_BITS'($urandom);
    return inst;
  endfunction

  // reads and writes the same register, each waits for the previous
  function automatic inst_t chain_inst();
    inst_t inst;
    inst            = random_inst();
    inst.op         = add;
    inst.src1.valid = 1'b1;
    inst.src1.idx   = LREG_BITS'(CHAIN_REG);
    inst.dst.valid  = 1'b1;
    inst.dst.idx    = LREG_BITS'(CHAIN_REG);
    return inst;
  endfunction

  // idle for gap cycles, then hold the instruction until accepted
  task automatic send_inst(input inst_t inst, input int gap);
    @(posedge clk);
    inst_valid_i <= 1'b0;
    repeat (gap) @(posedge clk);
    inst_valid_i <= 1'b1;
    inst_i       <= inst;
    do
    begin
      @(negedge clk);
      if (!inst_accept_o)
        stall_seen = 1'b1;
    end
    while (!inst_accept_o);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // monitor, samples at the falling edge for the coming rising edge
  ////////////////////////////////////////////////////////////////////////////
  always @(negedge clk)
  begin : monitor
    renamed_inst_t        exp;
    wb_rec_t              rec;
    logic                 free_pend;
    logic [PREG_BITS-1:0] free_preg;
    logic                 exp_accept;
    free_pend = 1'b0;
    free_preg = '0;
    if (rst_n)
    begin
      // room in the queue and a preg for a destination, before this cycle's moves
      exp_accept = (exp_q.size() < ISQ_DEPTH) &&
                   ((free_q.size() != 0) || !inst_i.dst.valid);
      check_accept(inst_accept_o, exp_accept);
      // issue is judged on ready times before this cycle's writeback
      if (issue_valid_o)
      begin
        if (exp_q.size() == 0)
          report_failure("an instruction issued with none accepted and pending");
        else
        begin
          exp = exp_q.pop_front();
          check_issue(issue_inst_o, exp);
          if (!sources_ready(exp, cycle))
            report_failure("an instruction issued before its source preg was written back");
          issued++;
          if (exp.pdst_valid)
          begin
            rec.due       = cycle + EXEC_LAT;
            rec.pdst      = exp.pdst;
            rec.old_valid = exp.old_valid;
            rec.old_preg  = exp.old_preg;
            wb_q.push_back(rec);
          end
        end
      end
      if ((wb_q.size() > 0) && (wb_q[0].due == cycle))
      begin
        rec = wb_q.pop_front();
        if (!wb_valid_o)
          report_failure("a writeback pulse was missing at its expected cycle");
        else
          check_wb_preg(wb_preg_o, rec.pdst);
        // dependents may go one cycle after the pulse
        ready_at[rec.pdst] = cycle + 1;
        free_pend = rec.old_valid;
        free_preg = rec.old_preg;
        wb_count++;
      end
      else if (wb_valid_o)
        report_failure("a writeback pulse came with no instruction due");
      if (inst_valid_i && inst_accept_o)
      begin
        if (inst_i.dst.valid && (free_q.size() == 0))
          report_failure("a destination was accepted while no preg was free");
        else
          exp_q.push_back(rename_inst(inst_i));
        accepted++;
      end
      // freed preg joins behind any pop on the same edge
      if (free_pend)
        free_q.push_back(free_preg);
      cycle++;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // watchdog
  ////////////////////////////////////////////////////////////////////////////
  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("the run stalled: %0d cycles passed with %0d of %0d instructions issued",
             WATCHDOG_CYCLES, issued, NUM_INSTS);
    $display("TEST FAILED");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////////////////////
  initial
  begin
    int base_err;
    rst_n        = 1'b0;
    inst_valid_i = 1'b0;
    inst_i       = '0;
    void'($urandom(SEED));
    reset_model();
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;

    // random stream with gaps and incidental dependencies
    base_err = errors;
    for (int n = 0; n < NUM_RANDOM; n++)
      send_inst(random_inst(), $urandom_range(0, MAX_GAP));
    $display("test random_stream done: %0d sent, %0d errors", NUM_RANDOM, errors - base_err);

    // back to back dependent chain fills the queue
    base_err   = errors;
    stall_seen = 1'b0;
    for (int n = 0; n < NUM_CHAIN; n++)
      send_inst(chain_inst(), 0);
    @(posedge clk);
    inst_valid_i <= 1'b0;
    if (!stall_seen)
      report_failure("inst_accept_o never dropped during the dependent burst");
    $display("test backpressure_burst done: %0d sent, %0d errors", NUM_CHAIN, errors - base_err);

    // drain, then look for lost or extra instructions
    base_err = errors;
    while (!((issued >= NUM_INSTS) && (wb_q.size() == 0)))
      @(posedge clk);
    repeat (EXEC_LAT + 2) @(posedge clk);
    if ((issued != accepted) || (exp_q.size() != 0))
      report_failure("issued instructions do not match the accepted ones one for one");
    $display("test drain_and_count done: %0d issued, %0d errors", issued, errors - base_err);

    $display("summary: %0d accepted, %0d issued, %0d writebacks, %0d checks, %0d errors",
             accepted, issued, wb_count, checks, errors);
    if (errors == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

// File: src.f
+incdir+sim
hw/rename_pkg.sv
hw/rename_ifs.sv
hw/preg_alloc.sv
hw/rename_line.sv
hw/issue_queue.sv
hw/exec_pipe.sv
hw/rename_unit_top.sv
sim/rename_tb.sv

// File: Bender.yml
package:
  name: rename_unit

sources:
  - files:
      - hw/rename_pkg.sv
      - hw/rename_ifs.sv
      - hw/preg_alloc.sv
      - hw/rename_line.sv
      - hw/issue_queue.sv
      - hw/exec_pipe.sv
      - hw/rename_unit_top.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/rename_tb.sv
